//--- src/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // ****************************************
    // Widths
    // ****************************************

    localparam int xlen    = 32;
    localparam int shamt_w = 5;     // Shift amount is taken from the low bits of operand b

    // ****************************************
    // Operation codes
    // ****************************************

    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_sll  = 4'h2,
        op_slt  = 4'h3,
        op_sltu = 4'h4,
        op_xor  = 4'h5,
        op_srl  = 4'h6,
        op_sra  = 4'h7,
        op_or   = 4'h8,
        op_and  = 4'h9
    } alu_op_e;

    // ****************************************
    // Request and response
    // ****************************************

    typedef struct packed {
        alu_op_e         op;
        logic [xlen-1:0] operand_a;
        logic [xlen-1:0] operand_b;
    } alu_req_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic            zero;      // High exactly when result is all zeros
    } alu_resp_t;

    // The three operations served by the shift unit
    function automatic logic is_shift(input alu_op_e op);
        return (op == op_sll) || (op == op_srl) || (op == op_sra);
    endfunction

endpackage

`default_nettype wire

//--- src/alu_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module alu_shifter (
    input  alu_pkg::alu_req_t         req,
    output logic [alu_pkg::xlen-1:0]  shift_result
);

    // Mirrors a word end for end so the right-shift network can shift left too
    function automatic logic [alu_pkg::xlen-1:0] reverse_bits(
        input logic [alu_pkg::xlen-1:0] value
    );
        logic [alu_pkg::xlen-1:0] mirrored;
        for (int i = 0; i < alu_pkg::xlen; i++) begin
            mirrored[i] = value[alu_pkg::xlen-1-i];
        end
        return mirrored;
    endfunction

    // ****************************************
    // Operand preparation
    // ****************************************

    logic                                          shift_left;
    logic                                          fill_bit;
    logic [alu_pkg::shamt_w-1:0]                   shamt;
    logic [alu_pkg::xlen-1:0]                      shift_in;
    logic [alu_pkg::shamt_w:0][alu_pkg::xlen-1:0]  stage;
    logic [alu_pkg::xlen-1:0]                      shift_out;

    assign shift_left = (req.op == alu_pkg::op_sll);
    assign shamt      = req.operand_b[alu_pkg::shamt_w-1:0];

    // Only an arithmetic right shift drags the sign bit in from the top
    assign fill_bit = (req.op == alu_pkg::op_sra) ? req.operand_a[alu_pkg::xlen-1] : 1'b0;

    assign shift_in = shift_left ? reverse_bits(req.operand_a) : req.operand_a;

    // ****************************************
    // Logarithmic right-shift network
    // ****************************************

    // Stage i moves the word right by 2**i places when bit i of the amount is set,
    // so five stages cover every amount from 0 to 31
    assign stage[0] = shift_in;

    for (genvar i = 0; i < alu_pkg::shamt_w; i++) begin : g_stage
        assign stage[i+1] = shamt[i]
                          ? {{(2**i){fill_bit}}, stage[i][alu_pkg::xlen-1:2**i]}
                          : stage[i];
    end

    assign shift_out = stage[alu_pkg::shamt_w];

    // ****************************************
    // Result
    // ****************************************

    // A left shift was done mirrored, so mirror it back on the way out
    assign shift_result = shift_left ? reverse_bits(shift_out) : shift_out;

endmodule

`default_nettype wire

//--- src/alu_arith_logic.sv
`timescale 1ns/1ns
`default_nettype none

module alu_arith_logic (
    input  alu_pkg::alu_req_t         req,
    output logic [alu_pkg::xlen-1:0]  arith_result
);

    logic [alu_pkg::xlen-1:0] a;
    logic [alu_pkg::xlen-1:0] b;

    assign a = req.operand_a;
    assign b = req.operand_b;

    // ****************************************
    // Shared adder
    // ****************************************

    logic                     subtract;
    logic [alu_pkg::xlen-1:0] b_in;
    logic [alu_pkg::xlen:0]   sum;          // One extra bit holds the carry out
    logic                     carry_out;
    logic [alu_pkg::xlen-1:0] sum_word;

    // Subtraction and both compares work on a - b, formed as a + ~b + 1
    assign subtract = (req.op == alu_pkg::op_sub)
                   || (req.op == alu_pkg::op_slt)
                   || (req.op == alu_pkg::op_sltu);

    assign b_in = subtract ? ~b : b;

    assign sum = {1'b0, a} + {1'b0, b_in} + {{alu_pkg::xlen{1'b0}}, subtract};

    assign carry_out = sum[alu_pkg::xlen];
    assign sum_word  = sum[alu_pkg::xlen-1:0];

    // ****************************************
    // Comparisons
    // ****************************************

    logic sign_a;
    logic sign_b;
    logic less_signed;
    logic less_unsigned;

    assign sign_a = a[alu_pkg::xlen-1];
    assign sign_b = b[alu_pkg::xlen-1];

    // With mixed signs the difference can overflow, so the negative operand is the smaller
    assign less_signed = (sign_a != sign_b) ? sign_a : sum_word[alu_pkg::xlen-1];

    // No carry out of a + ~b + 1 means a borrow was needed
    assign less_unsigned = ~carry_out;

    // ****************************************
    // Result select
    // ****************************************

    always_comb begin
        unique case (req.op)
            alu_pkg::op_add,
            alu_pkg::op_sub:  arith_result = sum_word;
            alu_pkg::op_slt:  arith_result = {{(alu_pkg::xlen-1){1'b0}}, less_signed};
            alu_pkg::op_sltu: arith_result = {{(alu_pkg::xlen-1){1'b0}}, less_unsigned};
            alu_pkg::op_xor:  arith_result = a ^ b;
            alu_pkg::op_or:   arith_result = a | b;
            alu_pkg::op_and:  arith_result = a & b;
            default:          arith_result = sum_word;  // Shift ops, taken by the shifter
        endcase
    end

endmodule

`default_nettype wire

//--- src/alu_result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module alu_result_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  alu_pkg::alu_op_e          op,
    input  logic [alu_pkg::xlen-1:0]  shift_result,
    input  logic [alu_pkg::xlen-1:0]  arith_result,
    output logic                      resp_valid,
    output alu_pkg::alu_resp_t        resp
);

    // ****************************************
    // Path select and zero flag
    // ****************************************

    logic [alu_pkg::xlen-1:0] selected;
    logic                     zero;

    assign selected = alu_pkg::is_shift(op) ? shift_result : arith_result;
    assign zero     = (selected == '0);

    // ****************************************
    // Response register
    // ****************************************

    // One cycle of latency, and a new request may arrive on every edge
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            resp_valid <= req_valid;
            if (req_valid) begin
                resp.result <= selected;
                resp.zero   <= zero;
            end                          // Otherwise the last response is held
        end
    end

endmodule

`default_nettype wire

//--- src/alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  alu_pkg::alu_req_t    req,
    output logic                 resp_valid,
    output alu_pkg::alu_resp_t   resp
);

    logic [alu_pkg::xlen-1:0] shift_result;
    logic [alu_pkg::xlen-1:0] arith_result;

    // Both units see the request at once and work side by side
    alu_shifter u_shifter (
        .req          (req),
        .shift_result (shift_result)
    );

    alu_arith_logic u_arith_logic (
        .req          (req),
        .arith_result (arith_result)
    );

    // Picks one of the two results and registers it
    alu_result_stage u_result_stage (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .op           (req.op),
        .shift_result (shift_result),
        .arith_result (arith_result),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

endmodule

`default_nettype wire

//--- bench/alu_assert.sv
`timescale 1ns/1ns
`default_nettype none

module alu_assert (
    input logic                clk,
    input logic                rst,
    input logic                req_valid,
    input alu_pkg::alu_req_t   req,
    input logic                resp_valid,
    input alu_pkg::alu_resp_t  resp
);

    logic zero_shift;   // Valid shift request with an amount of zero

    assign zero_shift = req_valid
                     && ((req.op == alu_pkg::op_sll)
                      || (req.op == alu_pkg::op_srl)
                      || (req.op == alu_pkg::op_sra))
                     && (req.operand_b[alu_pkg::shamt_w-1:0] == '0);

    // ****************************************
    // Properties
    // ****************************************

    a_valid_latency: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (resp_valid == $past(req_valid)))
        else $error("resp_valid does not follow req_valid by one cycle");

    a_zero_flag: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> (resp.zero == (resp.result == '0)))
        else $error("zero flag disagrees with the result");

    a_shift_by_zero: assert property (@(posedge clk) disable iff (rst)
        zero_shift |=> (resp.result == $past(req.operand_a)))
        else $error("shift by zero changed operand a");

endmodule

bind alu_top alu_assert u_alu_assert (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp)
);

`default_nettype wire

//--- bench/alu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_tb;

    localparam int n_entries   = 38;
    localparam int cycle_limit = 4 * n_entries + 20;   // Longest gap plus the request itself

    logic                     clk;
    logic                     rst;
    logic                     req_valid;
    alu_pkg::alu_req_t        req;
    logic                     resp_valid;
    alu_pkg::alu_resp_t       resp;

    logic [31:0]              trace_mem [0:4*n_entries-1];   // Op, operand a, operand b, result

    integer                   seed;
    int                       cycle_count = 0;

    // Expected response for the request driven one cycle earlier
    logic                     exp_valid;
    logic [alu_pkg::xlen-1:0] exp_result;
    logic                     exp_zero;
    int                       exp_entry;

    // Last valid response, which the DUT must hold while idle
    logic [alu_pkg::xlen-1:0] held_result;
    logic                     held_zero;

    alu_top u_alu_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #10 clk = ~clk;

    // ****************************************
    // Timeout
    // ****************************************

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the trace was not finished within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // ****************************************
    // Helpers
    // ****************************************

    task automatic check_value(
        input logic [alu_pkg::xlen-1:0] actual,
        input logic [alu_pkg::xlen-1:0] expected,
        input string                    what
    );
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s got %h, expected %h",
                     $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // Idle cycle with junk on the operands, which must not reach the response
    task automatic drive_idle();
        req_valid     = 1'b0;
        req.op        = alu_pkg::op_add;
        req.operand_a = $random(seed);
        req.operand_b = $random(seed);
        exp_valid     = 1'b0;
    endtask

    task automatic send_entry(input int idx);
        req_valid     = 1'b1;
        req.op        = alu_pkg::alu_op_e'(trace_mem[4*idx][3:0]);
        req.operand_a = trace_mem[4*idx+1];
        req.operand_b = trace_mem[4*idx+2];
        exp_valid     = 1'b1;
        exp_result    = trace_mem[4*idx+3];
        exp_zero      = (exp_result == '0);   // Zero flag follows the result alone
        exp_entry     = idx;
    endtask

    task automatic check_response();
        check_value(32'(resp_valid), 32'(exp_valid), "resp_valid");
        if (exp_valid) begin
            check_value(resp.result, exp_result,
                        $sformatf("entry %0d result", exp_entry));
            check_value(32'(resp.zero), 32'(exp_zero),
                        $sformatf("entry %0d zero flag", exp_entry));
            held_result = exp_result;
            held_zero   = exp_zero;
        end else begin
            check_value(resp.result, held_result, "held result");
            check_value(32'(resp.zero), 32'(held_zero), "held zero flag");
        end
    endtask

    // ****************************************
    // Stimulus and checking
    // ****************************************

    initial begin
        int gap;
        int entry;

        seed        = 51;
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        exp_valid   = 1'b0;
        exp_result  = '0;
        exp_zero    = 1'b0;
        exp_entry   = 0;
        held_result = '0;   // Reset clears the response
        held_zero   = 1'b0;

        $readmemh("bench/alu_trace.txt", trace_mem);

        repeat (3) begin
            @(posedge clk);
            #1;
            check_response();   // resp_valid low and resp cleared while in reset
        end
        rst = 1'b0;

        gap   = 2;   // Stay idle for a while so resp_valid is seen low after reset
        entry = 0;
        while (entry < n_entries || exp_valid) begin
            if (gap > 0) begin
                drive_idle();
                gap = gap - 1;
            end else if (entry < n_entries) begin
                send_entry(entry);
                entry = entry + 1;
                gap   = $unsigned($random(seed)) % 4;
            end else begin
                drive_idle();
            end
            @(posedge clk);
            #1;
            check_response();
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/alu_trace.txt
// One operation per line: op code, operand a, operand b, expected result (hex)
// Op codes: 0 add, 1 sub, 2 sll, 3 slt, 4 sltu, 5 xor, 6 srl, 7 sra, 8 or, 9 and
7 80000000 00000000 80000000
7 80000000 00000001 c0000000
7 80000000 0000000d fffc0000
7 80000000 0000001f ffffffff
7 f0f0f0f0 00000004 ff0f0f0f
7 deadbeef 00000008 ffdeadbe
7 12345678 00000004 01234567
7 fffffff0 00000024 ffffffff
6 80000000 0000001f 00000001
6 deadbeef 00000000 deadbeef
6 deadbeef 00000004 0deadbee
6 f0000000 0000001c 0000000f
6 ffffffff 00000021 7fffffff
2 00000001 0000001f 80000000
2 deadbeef 00000000 deadbeef
2 deadbeef 00000004 eadbeef0
2 0000000f 0000001c f0000000
2 80000001 00000001 00000002
0 ffffffff 00000001 00000000
0 00000005 00000007 0000000c
0 7fffffff 00000001 80000000
1 00000000 00000001 ffffffff
1 12345678 12345678 00000000
1 00000010 00000003 0000000d
1 80000000 00000001 7fffffff
3 ffffffff 00000001 00000001
4 ffffffff 00000001 00000000
3 00000001 ffffffff 00000000
4 00000001 ffffffff 00000001
3 80000000 7fffffff 00000001
4 80000000 7fffffff 00000000
3 00000005 00000005 00000000
4 00000003 00000007 00000001
9 f0f0f0f0 0ff00ff0 00f000f0
8 f0f0f0f0 0ff00ff0 fff0fff0
5 f0f0f0f0 0ff00ff0 ff00ff00
5 a5a5a5a5 a5a5a5a5 00000000
9 aaaaaaaa 55555555 00000000

//--- alu.f
src/alu_pkg.sv
src/alu_shifter.sv
src/alu_arith_logic.sv
src/alu_result_stage.sv
src/alu_top.sv
bench/alu_assert.sv
bench/alu_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := alu_tb
FILELIST  := alu.f

SOURCES := $(shell cat $(FILELIST))
SIM     := obj_dir/V$(TOP)
TRACE   := bench/alu_trace.txt
LOG     := sim.log

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator status is ignored here; the log decides
run: $(SIM) $(TRACE)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
